// ==== dv/motion_axis_assertions.sv ====
`default_nettype none
`timescale 1ns/1ps

// Protocol checks, bound into the writer and the timer
module motion_axis_assertions (
  input logic                 CLK,
  input logic                 resetn,          // Active high
  input logic                 halt,            // Active low
  input logic                 move_wr,
  input logic                 buffer_full,
  input dda_pkg::slot_flags_t finished_flags,
  input logic                 step
);

  // Host honours back-pressure
  wr_not_full: assert property (@(posedge CLK) disable iff (resetn)
    move_wr |-> !buffer_full)
    else $error("move_wr strobed while buffer_full is high");

  // One slot retires per cycle, halt may copy many
  fin_one_bit: assert property (@(posedge CLK) disable iff (resetn)
    $past(halt) |-> $onehot0(finished_flags ^ $past(finished_flags)))
    else $error("finished flags changed in more than one slot outside halt");

  // Accumulator cleared by reset
  step_after_reset: assert property (@(posedge CLK)
    resetn |=> !step)
    else $error("step high in the cycle after reset");

endmodule

bind move_writer motion_axis_assertions i_writer_checks (
  .CLK            (CLK),
  .resetn         (resetn),
  .halt           (1'b1),
  .move_wr        (move_wr),
  .buffer_full    (buffer_full),
  .finished_flags (dda_pkg::slot_flags_t'(0)),  // Timer side checked below
  .step           (1'b0)
);

bind dda_timer motion_axis_assertions i_timer_checks (
  .CLK            (CLK),
  .resetn         (resetn),
  .halt           (halt),
  .move_wr        (1'b0),
  .buffer_full    (1'b0),
  .finished_flags (fin_q),
  .step           (step)
);

`default_nettype wire

// ==== dv/motion_axis_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "dda_config.svh"

module motion_axis_tb;

  localparam int NUM_MOVES  = 30;
  localparam int RESET_CYC  = 10;
  localparam int HALT_CYCLE = 5;   // Victim's load cycle to the cycle halt is low

  // DUT ports
  logic                         CLK;
  logic                         resetn;         // Active high reset
  logic                         move_wr;
  logic [`DDA_WIDTH-1:0]        move_duration;
  logic signed [`DDA_WIDTH-1:0] move_increment;
  logic signed [`DDA_WIDTH-1:0] move_increment_delta;
  logic [`DIV_WIDTH-1:0]        move_divisor;
  logic                         halt;           // Active low
  logic                         buffer_full;
  logic                         step;
  logic                         move_done;
  logic                         busy;

  // Model and scoreboard state
  logic [31:0]                  rand_state;
  logic signed [`DDA_WIDTH-1:0] model_acc;     // Carried across moves, halt keeps it
  dda_pkg::move_t               moves [NUM_MOVES];
  int                           exp_q [$];     // Step counts, one per move_done toggle
  int                           budget_cycles = 0;
  int                           step_cnt = 0;
  int                           done_toggles = 0;
  int                           runs_total = 0;
  logic                         done_seen = 1'b0;

  motion_axis i_dut (
    .CLK                  (CLK),
    .resetn               (resetn),
    .move_wr              (move_wr),
    .move_duration        (move_duration),
    .move_increment       (move_increment),
    .move_increment_delta (move_increment_delta),
    .move_divisor         (move_divisor),
    .halt                 (halt),
    .buffer_full          (buffer_full),
    .step                 (step),
    .move_done            (move_done),
    .busy                 (busy)
  );

  always #10 CLK = ~CLK;  // 20 ns period

  // Prints the reason, then the fail message, then stops
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_steps(input int actual, input int expected);
    if (actual != expected)
      stop_on_error($sformatf("** Error at %0t: move gave %0d steps, expected %0d",
                              $time, actual, expected));
  endtask

  task automatic check_move_done(input logic expected);
    if (move_done !== expected)
      stop_on_error($sformatf("** Error at %0t: move_done is %b, expected %b",
                              $time, move_done, expected));
  endtask

  task automatic check_full(input logic expected);
    if (buffer_full !== expected)
      stop_on_error($sformatf("** Error at %0t: buffer_full is %b, expected %b",
                              $time, buffer_full, expected));
  endtask

  task automatic check_busy(input logic expected);
    if (busy !== expected)
      stop_on_error($sformatf("** Error at %0t: busy is %b, expected %b",
                              $time, busy, expected));
  endtask

  task automatic check_step(input logic expected);
    if (step !== expected)
      stop_on_error($sformatf("** Error at %0t: step is %b, expected %b",
                              $time, step, expected));
  endtask

  // Xorshift32
  function automatic logic [31:0] next_random();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  // Increments in [2^61, 2^62), delta within +-2^55, so steps are frequent
  function automatic dda_pkg::move_t random_move(input int max_dur, input int max_div);
    dda_pkg::move_t m;
    logic [63:0]    wide;
    m.duration = 64'(next_random() % (max_dur + 1));
    wide = {next_random(), next_random()};
    m.increment = 64'sh2000_0000_0000_0000 + $signed(wide >> 3);
    wide = {next_random(), next_random()};
    m.increment_delta = $signed(wide >> 8) - 64'sh0080_0000_0000_0000;
    m.divisor = `DIV_WIDTH'(next_random() % (max_div + 1));
    return m;
  endfunction

  function automatic void build_moves();
    moves[0] = random_move(7, 3);                 // Single move
    for (int i = 1; i <= 28; i++) begin
      moves[i] = random_move(7, 3);
    end
    moves[1].duration = 64'd5;                    // Outlasts four writes
    moves[1].divisor  = 8'd3;
    moves[25].duration        = 64'd50;           // Halt victim, steps if left running
    moves[25].increment       = 64'sh7000_0000_0000_0000;
    moves[25].increment_delta = '0;
    moves[25].divisor         = 8'd10;
    moves[29] = random_move(2, 0);
    moves[29].divisor = 8'd255;                   // Exercises the divider
  endfunction

  // One clock of the accumulator, returns 1 when step is high in it
  function automatic int model_cycle(input bit tick, input logic signed [63:0] incr);
    int stepped;
    stepped = (model_acc > 0) ? 1 : 0;
    if (tick) model_acc = model_acc + incr;
    if (stepped != 0) model_acc = model_acc - `STEP_ROLLBACK;
    return stepped;
  endfunction

  // Step-high cycles from load to the trailing step of the last tick
  // Nonzero halt_at cuts the move, halt low that many cycles after load
  function automatic int expected_steps(input dda_pkg::move_t m, input int halt_at = 0);
    logic signed [63:0] incr;
    logic [63:0]        remain;
    int                 cnt;
    int                 steps;
    int                 live;
    bit                 last;
    incr   = m.increment;
    remain = m.duration;
    cnt    = 1;                                   // First tick after count of 1
    last   = 1'b0;
    steps  = model_cycle(1'b0, incr);             // Load cycle
    live   = 1;
    while (!last && (halt_at == 0 || live < halt_at)) begin
      if (cnt != 0) begin
        cnt   = cnt - 1;
        steps = steps + model_cycle(1'b0, incr);
      end else begin
        steps  = steps + model_cycle(1'b1, incr);
        incr   = incr + m.increment_delta;
        cnt    = int'(m.divisor);
        last   = (remain == 0);                   // duration+1 ticks
        remain = remain - 1;
      end
      live++;
    end
    if (!last) steps = steps + model_cycle(1'b0, '0);  // Halt cycle, tick blocked
    for (int i = 0; i < 2; i++) begin
      if (model_acc > 0) steps = steps + model_cycle(1'b0, '0);  // Idle rollback
    end
    return steps;
  endfunction

  // Strobe one move, honouring buffer_full at the edge that takes it
  task automatic write_move(input dda_pkg::move_t m, input bit runs);
    @(negedge CLK);
    while (buffer_full) @(negedge CLK);
    if (runs) begin
      exp_q.push_back(expected_steps(m));
      runs_total++;
    end
    @(posedge CLK);
    move_wr              <= 1'b1;
    move_duration        <= m.duration;
    move_increment       <= m.increment;
    move_increment_delta <= m.increment_delta;
    move_divisor         <= m.divisor;
    @(posedge CLK);
    move_wr <= 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge CLK);
    while (exp_q.size() != 0) @(negedge CLK);
  endtask

  // Counts step cycles between move_done toggles and compares per move
  always @(negedge CLK) begin
    if (!resetn) begin
      if (move_done !== done_seen) begin
        done_seen = move_done;
        done_toggles++;
        if (exp_q.size() == 0)
          stop_on_error("move_done toggled with no move outstanding");
        else
          check_steps(step_cnt, exp_q.pop_front());
        step_cnt = 0;
      end
      if (step) step_cnt++;
    end
  end

  // Watchdog
  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge CLK);
    stop_on_error($sformatf("Timeout: tests did not finish within %0d cycles", budget_cycles));
  end

  initial begin
    logic done_level;
    int   sum;
    CLK                  = 1'b0;
    resetn               = 1'b1;
    move_wr              = 1'b0;
    move_duration        = '0;
    move_increment       = '0;
    move_increment_delta = '0;
    move_divisor         = '0;
    halt                 = 1'b1;
    rand_state           = 32'h242badd9;
    model_acc            = '0;
    build_moves();
    sum = RESET_CYC;
    for (int i = 0; i < NUM_MOVES; i++) begin
      sum += (int'(moves[i].duration) + 1) * (int'(moves[i].divisor) + 1) + 10;
    end
    budget_cycles = 2 * sum;

    repeat (RESET_CYC) @(posedge CLK);
    resetn <= 1'b0;

    // Outputs quiet after reset
    @(negedge CLK);
    check_step(1'b0);
    check_busy(1'b0);
    check_full(1'b0);
    check_move_done(1'b0);

    // Single move, one toggle
    write_move(moves[0], 1'b1);
    wait_idle();
    check_move_done(1'b1);

    // Fill the ring, full until the first retire
    for (int i = 1; i <= 4; i++) begin
      write_move(moves[i], 1'b1);
    end
    @(negedge CLK);
    check_full(1'b1);
    done_level = move_done;
    while (move_done == done_level) @(negedge CLK);
    check_full(1'b0);
    wait_idle();

    // Random run against back-pressure
    for (int i = 5; i <= 24; i++) begin
      write_move(moves[i], 1'b1);
    end
    wait_idle();

    // Halt drops the running move and both queued ones
    write_move(moves[25], 1'b0);
    exp_q.push_back(expected_steps(moves[25], HALT_CYCLE));  // Cut short, still toggles
    runs_total++;
    write_move(moves[26], 1'b0);
    write_move(moves[27], 1'b0);
    @(posedge CLK);
    halt <= 1'b0;
    @(posedge CLK);
    halt <= 1'b1;
    repeat (30) begin
      @(negedge CLK);
      check_busy(1'b0);
      check_step(1'b0);
    end
    wait_idle();
    write_move(moves[28], 1'b1);        // Accumulator carried through halt
    wait_idle();

    // Slow divider
    write_move(moves[29], 1'b1);
    wait_idle();

    repeat (20) @(negedge CLK);
    check_move_done(logic'(runs_total % 2));
    if (exp_q.size() != 0 || done_toggles != runs_total) begin
      stop_on_error($sformatf("Saw %0d move completions, expected %0d",
                              done_toggles, runs_total));
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== include/dda_config.svh ====
`ifndef DDA_CONFIG_SVH
`define DDA_CONFIG_SVH

// Move ring geometry
`define MOVE_SLOTS 4      // Slots in the move ring
`define MOVE_IDX_BITS 2   // Slot index width, log2 of MOVE_SLOTS

// DDA datapath widths
`define DDA_WIDTH 64      // Duration, increment and accumulator
`define DIV_WIDTH 8       // Tick clock divisor

// Subtracted from the sub-step accumulator on every step
// Largest positive 64-bit signed value minus 100
`define STEP_ROLLBACK 64'sh7FFF_FFFF_FFFF_FF9B

`endif

// ==== motion_axis.f ====
+incdir+include
source/dda_pkg.sv
source/move_ring_if.sv
source/move_writer.sv
source/move_buffer.sv
source/dda_timer.sv
source/motion_axis.sv
dv/motion_axis_assertions.sv
dv/motion_axis_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the motion_axis testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
PASS_LINE='*** TEST PASSED ***'

verilator --binary --timing --assert -Wno-fatal \
  -f motion_axis.f --top-module motion_axis_tb \
  -Mdir "$BUILD_DIR" -o motion_axis_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/motion_axis_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qxF "$PASS_LINE" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== source/dda_pkg.sv ====
`default_nettype none

`include "dda_config.svh"

package dda_pkg;

  // One queued move as written by the host
  typedef struct packed {
    logic [`DDA_WIDTH-1:0]        duration;         // Ticks minus one
    logic signed [`DDA_WIDTH-1:0] increment;        // Starting step increment
    logic signed [`DDA_WIDTH-1:0] increment_delta;  // Added to increment per tick
    logic [`DIV_WIDTH-1:0]        divisor;          // Cycles per tick minus one
  } move_t;

  // One toggle flag per ring slot
  typedef logic [`MOVE_SLOTS-1:0] slot_flags_t;

  // Ring slot index, wraps naturally
  typedef logic [`MOVE_IDX_BITS-1:0] slot_idx_t;

endpackage

`default_nettype wire

// ==== source/dda_timer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "dda_config.svh"

module dda_timer (
  input  logic        CLK,
  input  logic        resetn,
  input  logic        halt,       // Active low, drops pending moves
  move_ring_if.dda    ring,
  output logic        step,       // Accumulator positive
  output logic        busy,       // Loading or executing
  output logic        move_done   // Toggles per finished move
);

  // Control state
  logic                         idle_q;       // No move loaded
  logic [`DIV_WIDTH-1:0]        tick_cnt_q;   // Divider countdown
  dda_pkg::slot_idx_t           rd_idx_q;     // Slot being consumed
  dda_pkg::slot_flags_t         fin_q;        // Finished toggle per slot
  logic [1:0]                   idle_dly_q;   // Idle history for move_done
  logic                         move_done_q;
  logic signed [`DDA_WIDTH-1:0] accum_q;      // Sub-step accumulator

  // Loaded move payload
  logic [`DDA_WIDTH-1:0]        remain_q;     // Ticks left after this one
  logic signed [`DDA_WIDTH-1:0] incr_q;       // Current step increment
  logic [`DIV_WIDTH-1:0]        divisor_q;

  dda_pkg::slot_flags_t         pending;
  logic [`MOVE_IDX_BITS:0]      pend_cnt;     // Pending slots, 0..MOVE_SLOTS
  logic                         slot_pending;
  logic                         loading;
  logic                         executing;
  logic                         load_go;
  logic                         tick;
  logic signed [`DDA_WIDTH-1:0] rollback;

  assign pending      = ring.ready_flags ^ fin_q;
  assign slot_pending = pending[rd_idx_q];
  assign loading      = idle_q & slot_pending;
  assign executing    = ~idle_q & slot_pending;

  // Halt wins over both load and execute
  assign load_go = loading & halt;
  assign tick    = executing & halt & (tick_cnt_q == '0);

  // Step and its rollback
  assign step     = (accum_q > 0);
  assign rollback = step ? `STEP_ROLLBACK : '0;

  // Pending count, distance from rd_idx to the writer's index
  always_comb begin
    pend_cnt = '0;
    for (int k = 0; k < `MOVE_SLOTS; k++) begin
      pend_cnt = pend_cnt + pending[k];
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      idle_q     <= 1'b1;
      tick_cnt_q <= `DIV_WIDTH'(1);
      rd_idx_q   <= '0;
      fin_q      <= '0;
    end else if (!halt) begin
      // Drop every pending move and catch up with the writer
      fin_q    <= ring.ready_flags;
      rd_idx_q <= rd_idx_q + pend_cnt[`MOVE_IDX_BITS-1:0];  // Full ring wraps to same
      idle_q   <= 1'b1;
    end else if (loading) begin
      tick_cnt_q <= `DIV_WIDTH'(1);  // First tick two cycles in
      idle_q     <= 1'b0;
    end else if (executing) begin
      if (tick_cnt_q != '0) begin
        tick_cnt_q <= tick_cnt_q - 1'b1;
      end else begin
        tick_cnt_q <= divisor_q;  // Next tick in divisor+1 cycles
        if (remain_q == '0) begin
          // Last tick, retire the slot
          fin_q[rd_idx_q] <= ~fin_q[rd_idx_q];
          rd_idx_q        <= rd_idx_q + 1'b1;
          idle_q          <= 1'b1;
        end
      end
    end
  end

  // Payload registers, loaded or stepped only
  always_ff @(posedge CLK) begin
    if (load_go) begin
      remain_q  <= ring.rd_entry.duration;
      incr_q    <= ring.rd_entry.increment;
      divisor_q <= ring.rd_entry.divisor;
    end else if (tick) begin
      remain_q <= remain_q - 1'b1;                      // Unused once zero
      incr_q   <= incr_q + ring.rd_entry.increment_delta;  // Slot stays put while running
    end
  end

  // Tick add and step rollback land in the same cycle
  always_ff @(posedge CLK) begin
    if (resetn) begin
      accum_q <= '0;
    end else if (tick) begin
      accum_q <= accum_q + incr_q - rollback;
    end else begin
      accum_q <= accum_q - rollback;  // Also while idle or halted
    end
  end

  // move_done flips two cycles after idle rises
  always_ff @(posedge CLK) begin
    if (resetn) begin
      idle_dly_q  <= 2'b11;  // Idle out of reset is no completion
      move_done_q <= 1'b0;
    end else begin
      idle_dly_q <= {idle_dly_q[0], idle_q};
      if (idle_dly_q == 2'b01) begin
        move_done_q <= ~move_done_q;
      end
    end
  end

  assign busy                = loading | executing;
  assign move_done           = move_done_q;
  assign ring.rd_idx         = rd_idx_q;
  assign ring.finished_flags = fin_q;

endmodule

`default_nettype wire

// ==== source/motion_axis.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "dda_config.svh"

// One stepper axis, host moves in, step pulses out
module motion_axis (
  input  logic                         CLK,
  input  logic                         resetn,
  input  logic                         move_wr,
  input  logic [`DDA_WIDTH-1:0]        move_duration,
  input  logic signed [`DDA_WIDTH-1:0] move_increment,
  input  logic signed [`DDA_WIDTH-1:0] move_increment_delta,
  input  logic [`DIV_WIDTH-1:0]        move_divisor,
  input  logic                         halt,          // Active low
  output logic                         buffer_full,
  output logic                         step,
  output logic                         move_done,
  output logic                         busy
);

  dda_pkg::move_t move_in;

  // Host fields into one move record
  assign move_in = '{
    duration:        move_duration,
    increment:       move_increment,
    increment_delta: move_increment_delta,
    divisor:         move_divisor
  };

  move_ring_if #(.entry_t(dda_pkg::move_t)) ring ();

  move_writer i_writer (
    .CLK         (CLK),
    .resetn      (resetn),
    .move_wr     (move_wr),
    .move_in     (move_in),
    .buffer_full (buffer_full),
    .ring        (ring.writer)
  );

  move_buffer #(
    .entry_t (dda_pkg::move_t),
    .SLOTS   (`MOVE_SLOTS)
  ) i_buffer (
    .CLK  (CLK),
    .ring (ring.store)
  );

  dda_timer i_timer (
    .CLK       (CLK),
    .resetn    (resetn),
    .halt      (halt),
    .ring      (ring.dda),
    .step      (step),
    .busy      (busy),
    .move_done (move_done)
  );

endmodule

`default_nettype wire

// ==== source/move_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "dda_config.svh"

// Ring slot storage, any payload type and depth
module move_buffer #(
  parameter type entry_t = dda_pkg::move_t,
  parameter int  SLOTS   = `MOVE_SLOTS
) (
  input  logic         CLK,
  move_ring_if.store   ring
);

  entry_t slots_q [SLOTS];  // Payload only, no reset

  // Single write port from the move writer
  always_ff @(posedge CLK) begin
    if (ring.wr_en) begin
      slots_q[ring.wr_idx] <= ring.wr_entry;
    end
  end

  // Async read so the timer loads within one cycle
  assign ring.rd_entry = slots_q[ring.rd_idx];

endmodule

`default_nettype wire

// ==== source/move_ring_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// Move ring between writer, slot store and DDA timer
interface move_ring_if #(
  parameter type entry_t = dda_pkg::move_t
);

  // Write side
  logic                  wr_en;
  dda_pkg::slot_idx_t    wr_idx;
  entry_t                wr_entry;

  // Read side
  dda_pkg::slot_idx_t    rd_idx;
  entry_t                rd_entry;   // Async read of slot rd_idx

  // Toggle flags, slot pending when they differ
  dda_pkg::slot_flags_t  ready_flags;     // Owned by writer
  dda_pkg::slot_flags_t  finished_flags;  // Owned by timer

  modport writer (
    output wr_en, wr_idx, wr_entry, ready_flags,
    input  finished_flags
  );

  modport store (
    input  wr_en, wr_idx, wr_entry, rd_idx,
    output rd_entry
  );

  modport dda (
    output rd_idx, finished_flags,
    input  rd_entry, ready_flags
  );

endinterface

`default_nettype wire

// ==== source/move_writer.sv ====
`default_nettype none
`timescale 1ns/1ps

module move_writer (
  input  logic            CLK,
  input  logic            resetn,
  input  logic            move_wr,      // Host strobe, one move per pulse
  input  dda_pkg::move_t  move_in,
  output logic            buffer_full,  // Advisory, all slots pending
  move_ring_if.writer     ring
);

  dda_pkg::slot_idx_t    wr_idx_q;   // Next slot to fill
  dda_pkg::slot_flags_t  ready_q;    // Ready toggle per slot
  dda_pkg::slot_flags_t  pending;

  // Slot holds a move until the timer flips its finished flag
  assign pending     = ready_q ^ ring.finished_flags;
  assign buffer_full = &pending;

  // Write port, slot written on the same edge the flag toggles
  assign ring.wr_en       = move_wr;
  assign ring.wr_idx      = wr_idx_q;
  assign ring.wr_entry    = move_in;
  assign ring.ready_flags = ready_q;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      wr_idx_q <= '0;
      ready_q  <= '0;
    end else if (move_wr) begin
      // No full check here, host honours buffer_full
      ready_q[wr_idx_q] <= ~ready_q[wr_idx_q];  // Mark slot ready
      wr_idx_q          <= wr_idx_q + 1'b1;     // Wraps at ring size
    end
  end

endmodule

`default_nettype wire
